//--- flist.f
video_mix_pkg.sv
video_stream_if.sv
video_frame_gate.sv
video_key_mixer.sv
video_overlay_top.sv
tb_video_overlay_top.sv

//--- Bender.yml
package:
  name: video_overlay

sources:
  - video_mix_pkg.sv
  - video_stream_if.sv
  - video_frame_gate.sv
  - video_key_mixer.sv
  - video_overlay_top.sv
  - target: test
    files:
      - tb_video_overlay_top.sv

//--- tb_video_overlay_top.sv
/*
 * Testbench for the video overlay top level. A table of cases is applied in
 * order. Each case sends frames on both inputs, builds the expected output
 * from the gating and key rules, and checks every output beat.
 */

`timescale 1ns/1ps

module tb_video_overlay_top;
    import video_mix_pkg::*;

    localparam int NUM_TESTS = 5;
    localparam int TIMEOUT   = 500;
    localparam int MAX_PIX   = 64;

    typedef struct {
        int    frames;
        int    ppl;
        int    lines;
        bit    main_en;
        bit    main_skip;
        bit    ovl_en;
        bit    ovl_skip;
        int    key_mode;
        bit    bp;
        string name;
    } test_row_t;

    typedef struct packed {
        logic tuser;
        logic tlast;
        rgb_t tdata;
    } beat_t;

    // key_mode 0 leaves keys clear, 1 sets every key, 2 takes random keys
    test_row_t rows [0:NUM_TESTS-1] = '{
        '{2, 4, 3, 1'b1, 1'b0, 1'b1, 1'b0, 2, 1'b0, "mixed key"},
        '{1, 4, 2, 1'b1, 1'b0, 1'b0, 1'b1, 1, 1'b0, "overlay dropped"},
        '{1, 4, 2, 1'b0, 1'b1, 1'b0, 1'b1, 2, 1'b0, "main dropped"},
        '{1, 4, 2, 1'b0, 1'b0, 1'b1, 1'b0, 2, 1'b0, "main held"},
        '{2, 5, 3, 1'b1, 1'b0, 1'b1, 1'b0, 2, 1'b1, "back-pressure"}
    };

    logic aclk, aresetn, aclken;
    logic main_enable, main_skip, main_busy, ovl_enable, ovl_skip, ovl_busy;
    logic [TUSER_W-1:0] s_main_tuser, s_ovl_tuser, m_tuser;
    logic [RGB_W-1:0]   s_main_tdata, m_tdata;
    logic [OVL_W-1:0]   s_ovl_tdata;
    logic s_main_tlast, s_main_tvalid, s_main_tready;
    logic s_ovl_tlast, s_ovl_tvalid, s_ovl_tready;
    logic m_tlast, m_tvalid, m_tready;

    rgb_t        main_pix [0:MAX_PIX-1];
    ovl_pixel_t  ovl_pix  [0:MAX_PIX-1];
    beat_t       exp_q [$];
    beat_t       exp_beat;
    rgb_t        held_data;
    logic [31:0] bp_rand;
    int seed, errors, failed_tests, beats_seen, cur, t;
    bit bp_on, timeout_hit, stall_prev;

    video_overlay_top video_overlay_top_i (.*);

    always #50 aclk = ~aclk;

    always @(posedge aclk) begin
        bp_rand = bp_on ? $random(seed) : 32'h1;
        m_tready <= bp_rand[0];
    end

    task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("** Error at %0t: %s expected %h, got %h", $time, sig, exp_v, act_v);
        errors++;
    endtask

    task automatic note_timeout(input string what);
        if (!timeout_hit) begin
            $display("timeout at %0t while waiting for %s", $time, what);
            errors++;
        end
        timeout_hit = 1'b1;
    endtask

    // outputs are sampled at the falling edge, one half cycle before the
    // rising edge that transfers the beat
    always @(negedge aclk) begin
        if (aresetn) begin
            if (stall_prev && (m_tvalid !== 1'b1 || m_tdata !== held_data)) begin
                report_mismatch("m_tdata (stalled)", held_data, m_tdata);
            end
            if (m_tvalid && m_tready) begin
                beats_seen++;
                if (exp_q.size() == 0) begin
                    $display("unexpected output beat at %0t, data %h", $time, m_tdata);
                    errors++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    if (m_tdata !== exp_beat.tdata)
                        report_mismatch("m_tdata", exp_beat.tdata, m_tdata);
                    if (m_tuser[0] !== exp_beat.tuser)
                        report_mismatch("m_tuser", exp_beat.tuser, m_tuser);
                    if (m_tlast !== exp_beat.tlast)
                        report_mismatch("m_tlast", exp_beat.tlast, m_tlast);
                end
            end
            stall_prev = m_tvalid && !m_tready;
            held_data  = m_tdata;
        end
    end

    task automatic build_frames();
        int fsize;
        int i;
        bit main_open;
        bit mixed;
        beat_t b;
        logic [31:0] r;
        fsize = rows[cur].ppl * rows[cur].lines;
        for (i = 0; i < rows[cur].frames * fsize; i++) begin
            r = $random(seed);
            main_pix[i] = r[RGB_W-1:0];
            r = $random(seed);
            ovl_pix[i] = r[OVL_W-1:0];
            if (rows[cur].key_mode < 2)
                ovl_pix[i].key = (rows[cur].key_mode == 1);
        end
        // a held main frame goes out after main is enabled again
        main_open = rows[cur].main_en || !rows[cur].main_skip;
        mixed = rows[cur].ovl_en;
        for (i = 0; main_open && i < rows[cur].frames * fsize; i++) begin
            b.tuser = (i % fsize) == 0;
            b.tlast = (i % rows[cur].ppl) == rows[cur].ppl - 1;
            b.tdata = (mixed && ovl_pix[i].key) ? ovl_pix[i].rgb : main_pix[i];
            exp_q.push_back(b);
        end
    endtask

    task automatic drive_beats(input bit is_ovl);
        int fsize;
        int idx;
        int wait_cnt;
        bit rdy;
        fsize = rows[cur].ppl * rows[cur].lines;
        for (idx = 0; idx < rows[cur].frames * fsize && !timeout_hit; idx++) begin
            if (is_ovl) begin
                s_ovl_tvalid <= 1'b1;
                s_ovl_tdata  <= ovl_pix[idx];
                s_ovl_tuser  <= (idx % fsize) == 0;
                s_ovl_tlast  <= (idx % rows[cur].ppl) == rows[cur].ppl - 1;
            end else begin
                s_main_tvalid <= 1'b1;
                s_main_tdata  <= main_pix[idx];
                s_main_tuser  <= (idx % fsize) == 0;
                s_main_tlast  <= (idx % rows[cur].ppl) == rows[cur].ppl - 1;
            end
            wait_cnt = 0;
            rdy = 1'b0;
            while (!rdy && wait_cnt < TIMEOUT) begin
                @(negedge aclk);
                rdy = is_ovl ? s_ovl_tready : s_main_tready;
                wait_cnt++;
            end
            @(posedge aclk);
            if (!rdy)
                note_timeout(is_ovl ? "overlay input ready" : "main input ready");
        end
        if (is_ovl)
            s_ovl_tvalid <= 1'b0;
        else
            s_main_tvalid <= 1'b0;
    endtask

    // the pending main frame start must wait, then go out once enabled
    task automatic hold_then_release();
        int k;
        for (k = 0; k < 10; k++) begin
            @(negedge aclk);
            if (s_main_tready !== 1'b0) report_mismatch("s_main_tready", 0, s_main_tready);
            if (m_tvalid !== 1'b0) report_mismatch("m_tvalid", 0, m_tvalid);
        end
        @(posedge aclk);
        main_enable <= 1'b1;
    endtask

    task automatic run_test(input int idx);
        int errs_before;
        int wait_cnt;
        errs_before = errors;
        cur = idx;
        beats_seen = 0;
        build_frames();
        bp_on = rows[idx].bp;
        @(posedge aclk);
        main_enable <= rows[idx].main_en;
        main_skip   <= rows[idx].main_skip;
        ovl_enable  <= rows[idx].ovl_en;
        ovl_skip    <= rows[idx].ovl_skip;
        @(posedge aclk);
        fork
            drive_beats(1'b0);
            drive_beats(1'b1);
            if (!rows[idx].main_en && !rows[idx].main_skip) hold_then_release();
        join
        wait_cnt = 0;
        while (exp_q.size() != 0 && wait_cnt < TIMEOUT) begin
            @(negedge aclk);
            wait_cnt++;
        end
        if (exp_q.size() != 0) note_timeout("expected output beats");
        repeat (5) @(negedge aclk);
        if (!rows[idx].ovl_en && ovl_busy !== 1'b0) report_mismatch("ovl_busy", 0, ovl_busy);
        if (!rows[idx].main_en && rows[idx].main_skip && beats_seen != 0) begin
            $display("output beats appeared for a dropped main frame");
            errors++;
        end
        bp_on = 1'b0;
        if (errors != errs_before) failed_tests++;
        $display("test %0d %s: %s", idx + 1, rows[idx].name,
                 (errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        seed = 43;
        errors = 0;
        failed_tests = 0;
        timeout_hit = 1'b0;
        stall_prev = 1'b0;
        bp_on = 1'b0;
        aclk = 1'b0;
        aresetn = 1'b0;
        aclken = 1'b1;
        {main_enable, main_skip, ovl_enable, ovl_skip} = 4'b1010;
        {s_main_tuser, s_main_tlast, s_main_tdata, s_main_tvalid} = '0;
        {s_ovl_tuser, s_ovl_tlast, s_ovl_tdata, s_ovl_tvalid} = '0;
        m_tready = 1'b1;
        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;
        @(negedge aclk);
        if (m_tvalid !== 1'b0) report_mismatch("m_tvalid", 0, m_tvalid);
        if (main_busy !== 1'b1) report_mismatch("main_busy", 1, main_busy);
        if (ovl_busy !== 1'b1) report_mismatch("ovl_busy", 1, ovl_busy);
        if (errors != 0) failed_tests++;
        $display("test 0 after reset: %s", (errors == 0) ? "ok" : "FAILED");
        for (t = 0; t < NUM_TESTS && !timeout_hit; t++) begin
            run_test(t);
        end
        $display("tests run %0d, failed %0d, errors %0d", t + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- video_overlay_top.sv
/*
 * Top level of the overlay path. The main and overlay inputs each pass a
 * frame gate and then meet in the key mixer. All streams are plain ports
 * here; enable and skip levels per layer, busy reports each gate's state.
 */

`timescale 1ns/1ps

module video_overlay_top (
    input  logic                              aclk,
    input  logic                              aresetn,
    input  logic                              aclken,

    input  logic                              main_enable,
    input  logic                              main_skip,
    output logic                              main_busy,
    input  logic                              ovl_enable,
    input  logic                              ovl_skip,
    output logic                              ovl_busy,

    input  logic [video_mix_pkg::TUSER_W-1:0] s_main_tuser,
    input  logic                              s_main_tlast,
    input  logic [video_mix_pkg::RGB_W-1:0]   s_main_tdata,
    input  logic                              s_main_tvalid,
    output logic                              s_main_tready,

    input  logic [video_mix_pkg::TUSER_W-1:0] s_ovl_tuser,
    input  logic                              s_ovl_tlast,
    input  logic [video_mix_pkg::OVL_W-1:0]   s_ovl_tdata,
    input  logic                              s_ovl_tvalid,
    output logic                              s_ovl_tready,

    output logic [video_mix_pkg::TUSER_W-1:0] m_tuser,
    output logic                              m_tlast,
    output logic [video_mix_pkg::RGB_W-1:0]   m_tdata,
    output logic                              m_tvalid,
    input  logic                              m_tready
);
    import video_mix_pkg::*;

    video_stream_if #(.payload_t(rgb_t))       main_in_if ();
    video_stream_if #(.payload_t(ovl_pixel_t)) ovl_in_if ();
    video_stream_if #(.payload_t(rgb_t))       main_gated_if ();
    video_stream_if #(.payload_t(ovl_pixel_t)) ovl_gated_if ();

    // plain input ports onto the gate inputs
    assign main_in_if.tuser  = s_main_tuser;
    assign main_in_if.tlast  = s_main_tlast;
    assign main_in_if.tdata  = s_main_tdata;
    assign main_in_if.tvalid = s_main_tvalid;
    assign s_main_tready     = main_in_if.tready;

    assign ovl_in_if.tuser   = s_ovl_tuser;
    assign ovl_in_if.tlast   = s_ovl_tlast;
    assign ovl_in_if.tdata   = s_ovl_tdata;
    assign ovl_in_if.tvalid  = s_ovl_tvalid;
    assign s_ovl_tready      = ovl_in_if.tready;

    video_frame_gate #(.payload_t(rgb_t)) gate_main (
        .aclk    (aclk),
        .aresetn (aresetn),
        .aclken  (aclken),
        .enable  (main_enable),
        .skip    (main_skip),
        .busy    (main_busy),
        .s       (main_in_if),
        .m       (main_gated_if)
    );

    video_frame_gate #(.payload_t(ovl_pixel_t)) gate_ovl (
        .aclk    (aclk),
        .aresetn (aresetn),
        .aclken  (aclken),
        .enable  (ovl_enable),
        .skip    (ovl_skip),
        .busy    (ovl_busy),
        .s       (ovl_in_if),
        .m       (ovl_gated_if)
    );

    video_key_mixer mixer (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .aclken   (aclken),
        .main     (main_gated_if),
        .ovl      (ovl_gated_if),
        .m_tuser  (m_tuser),
        .m_tlast  (m_tlast),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready)
    );

endmodule

//--- video_key_mixer.sv
/*
 * Key mixer for the main RGB stream and the keyed overlay stream.
 * The mix mode is fixed per frame at the main frame start. While mixing,
 * one beat of each stream is joined and the overlay colour replaces the
 * main colour where its key is set. One-deep registered output, one cycle.
 */

`timescale 1ns/1ps

module video_key_mixer (
    input  logic                               aclk,
    input  logic                               aresetn,
    input  logic                               aclken,
    video_stream_if.sink                       main,
    video_stream_if.sink                       ovl,
    output logic [video_mix_pkg::TUSER_W-1:0]  m_tuser,
    output logic                               m_tlast,
    output video_mix_pkg::rgb_t                m_tdata,
    output logic                               m_tvalid,
    input  logic                               m_tready
);
    import video_mix_pkg::*;

    logic mix_q;
    logic mix_now;
    logic load_en;
    logic main_fire;
    logic ovl_fire;
    rgb_t sel_rgb;

    // a new frame takes its mode from the overlay being at its own frame
    // start in the same cycle, otherwise the running mode is kept
    assign mix_now = main.tuser[0] ? (ovl.tvalid && ovl.tuser[0]) : mix_q;

    // the output stage can take a beat when empty or when it drains now
    assign load_en = !m_tvalid || m_tready;

    assign main.tready = load_en && (!mix_now || ovl.tvalid);
    assign ovl.tready  = load_en && mix_now && main.tvalid;

    assign main_fire = aclken && main.tvalid && main.tready;
    assign ovl_fire  = aclken && ovl.tvalid && ovl.tready;

    always_comb begin
        if (mix_now && ovl.tdata.key) begin
            sel_rgb = ovl.tdata.rgb;
        end else begin
            sel_rgb = main.tdata;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            mix_q <= 1'b0;
        end else if (main_fire && main.tuser[0]) begin
            mix_q <= mix_now;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_tvalid <= 1'b0;
        end else if (aclken && load_en) begin
            m_tvalid <= main.tvalid && main.tready;
        end
    end

    // payload only moves with an accepted beat
    always_ff @(posedge aclk) begin
        if (main_fire) begin
            m_tuser <= main.tuser;
            m_tlast <= main.tlast;
            m_tdata <= sel_rgb;
        end
    end

    // both streams must be frame aligned whenever they are joined
    property joined_sof_aligned;
        @(posedge aclk) disable iff (!aresetn)
        (main_fire && ovl_fire) |-> (ovl.tuser[0] == main.tuser[0]);
    endproperty

    assert property (joined_sof_aligned)
        else $error("overlay and main frame starts out of step");

    property out_hold;
        @(posedge aclk) disable iff (!aresetn)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata));
    endproperty

    assert property (out_hold)
        else $error("output beat changed while stalled");

endmodule

//--- video_frame_gate.sv
/*
 * Frame-accurate gate for one video stream. The gate only changes state at
 * a start-of-frame beat; a closed gate drops whole frames when skip is high
 * or holds the frame start back until it opens again when skip is low.
 * Zero latency, purely combinational on the data path.
 */

`timescale 1ns/1ps

module video_frame_gate #(
    parameter type payload_t = video_mix_pkg::rgb_t
) (
    input  logic           aclk,
    input  logic           aresetn,
    input  logic           aclken,
    input  logic           enable,
    input  logic           skip,
    output logic           busy,
    video_stream_if.sink   s,
    video_stream_if.source m
);
    logic busy_q;
    logic sof;
    logic sof_accept;

    assign sof        = s.tvalid && s.tuser[0];
    assign sof_accept = aclken && sof && s.tready;

    // gate state for the frame in flight, sampled at every frame start
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy_q <= 1'b1;
        end else if (sof_accept) begin
            busy_q <= enable;
        end
    end

    // a pending frame start already follows enable, so the first pixel of
    // a frame is gated with the same decision as the rest of it
    assign busy = sof ? enable : busy_q;

    // when closed, a frame start waits unless skip is set, and the body of
    // a closed frame is always swallowed
    assign s.tready = busy ? m.tready : (skip || !s.tuser[0]);

    assign m.tuser  = s.tuser;
    assign m.tlast  = s.tlast;
    assign m.tdata  = payload_t'(s.tdata);
    assign m.tvalid = s.tvalid && busy;

    // once a frame start is taken while disabled, nothing leaves the gate
    // until the next frame start shows up at the input
    property closed_frame_blocked;
        @(posedge aclk) disable iff (!aresetn)
        (sof_accept && !enable) |=> (!m.tvalid until (s.tvalid && s.tuser[0]));
    endproperty

    assert property (closed_frame_blocked)
        else $error("frame gate passed a beat of a closed frame");

endmodule

//--- video_stream_if.sv
/*
 * Valid/ready video stream between blocks inside the overlay design.
 * The payload type is a parameter so one interface carries plain RGB or
 * keyed overlay pixels. tuser bit 0 marks frame start, tlast marks line end.
 */

`timescale 1ns/1ps

interface video_stream_if #(
    parameter type payload_t = video_mix_pkg::rgb_t
) ();
    import video_mix_pkg::*;

    logic [TUSER_W-1:0] tuser;
    logic               tlast;
    payload_t           tdata;
    logic               tvalid;
    logic               tready;

    // the block that produces beats
    modport source (
        output tuser,
        output tlast,
        output tdata,
        output tvalid,
        input  tready
    );

    // the block that consumes beats
    modport sink (
        input  tuser,
        input  tlast,
        input  tdata,
        input  tvalid,
        output tready
    );

endinterface

//--- video_mix_pkg.sv
/*
 * Pixel types and stream widths for the two-layer video overlay path.
 * Every RTL file and the testbench draw the RGB and overlay pixel formats
 * and the tuser width from here, so both layers agree on one layout.
 */

package video_mix_pkg;

    // width of one colour channel
    localparam int CH_W = 8;

    // tuser carries only the start-of-frame flag in bit 0
    localparam int TUSER_W = 1;

    // plain RGB pixel, red in the top byte
    typedef struct packed {
        logic [CH_W-1:0] r;
        logic [CH_W-1:0] g;
        logic [CH_W-1:0] b;
    } rgb_t;

    // overlay pixel; a set key means the overlay colour wins over main
    typedef struct packed {
        logic key;
        rgb_t rgb;
    } ovl_pixel_t;

    // flat widths for the plain ports at the top level
    localparam int RGB_W = $bits(rgb_t);
    localparam int OVL_W = $bits(ovl_pixel_t);

endpackage
